// File: hw/ifu_pkg.sv
package ifu_pkg;

    // lane and port count, fixed for the dual-issue front end
    localparam int NUM_LANES  = 2;

    // instruction queue geometry
    localparam int FIFO_DEPTH = 16;
    localparam int PTR_W      = 4;
    localparam int CNT_W      = 5;    // holds 0..16

    // free entries needed before a new pair may be requested:
    // one pair in memory, one in the lanes, one being asked for
    localparam int ROOM_MIN   = 6;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;

    // opcodes the predecode lanes recognise
    localparam logic [5:0] OP_J   = 6'h02;
    localparam logic [5:0] OP_JAL = 6'h03;
    localparam logic [5:0] OP_BEQ = 6'h04;
    localparam logic [5:0] OP_BNE = 6'h05;
    localparam logic [5:0] OP_LW  = 6'h23;
    localparam logic [5:0] OP_SW  = 6'h2b;

    typedef enum logic [1:0] {
        FS_IDLE,       // waiting for queue room
        FS_REQ,        // req high, waiting for ack
        FS_RELEASE     // req low, waiting for ack to drop
    } fetch_state_e;

    typedef enum logic [2:0] {
        IC_ALU,
        IC_BRANCH,
        IC_JUMP,
        IC_LOAD,
        IC_STORE,
        IC_OTHER
    } inst_class_e;

endpackage

// File: hw/fetch_ctrl.sv
`timescale 1ns/1ns

module fetch_ctrl import ifu_pkg::*; (
    input  logic                 clk,
    input  logic                 fifo_rst,
    input  logic                 redirect,
    input  logic [31:0]          redirect_pc,
    input  logic                 fifo_room,
    output logic                 mem_req,
    output logic [31:0]          mem_addr,
    input  logic                 mem_ack,
    input  logic [31:0]          mem_data0,
    input  logic [31:0]          mem_data1,
    input  logic                 mem_fault,
    output logic [NUM_LANES-1:0] lane_valid,
    output logic [31:0]          lane_pc [NUM_LANES],
    output logic [31:0]          lane_word [NUM_LANES],
    output logic [NUM_LANES-1:0] lane_fault
);

    fetch_state_e state;
    logic [31:0]  pc;          // next instruction to fetch
    logic [31:0]  req_addr;    // pair address held for the open request
    logic         discard;     // response in flight belongs to an old path
    logic         take;

    assign mem_req  = (state == FS_REQ);
    assign mem_addr = req_addr;

    // accept the returned pair only if no redirect has touched it
    assign take = (state == FS_REQ) && mem_ack && !discard && !redirect;

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            state   <= FS_IDLE;
            discard <= 1'b0;
        end else begin
            case (state)
                FS_IDLE: begin
                    if (fifo_room && !redirect) begin
                        state <= FS_REQ;
                    end
                end
                FS_REQ: begin
                    if (mem_ack) begin
                        state <= FS_RELEASE;
                    end else if (redirect) begin
                        discard <= 1'b1;    // finish the handshake, drop the data
                    end
                end
                FS_RELEASE: begin
                    if (!mem_ack) begin
                        state   <= FS_IDLE;
                        discard <= 1'b0;
                    end
                end
                default: state <= FS_IDLE;
            endcase
        end
    end

    // address latched once per request so it stays put while req is high
    always_ff @(posedge clk) begin
        if (state == FS_IDLE && fifo_room && !redirect) begin
            req_addr <= {pc[31:3], 3'b000};
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;
        end else if (take) begin
            pc <= req_addr + 32'd8;    // next aligned pair
        end
    end

    // one-cycle lane strobe, lane 0 skipped on an odd-word pc
    always_ff @(posedge clk) begin
        if (fifo_rst || redirect) begin
            lane_valid <= '0;
        end else if (take) begin
            lane_valid <= {1'b1, !pc[2]};
        end else begin
            lane_valid <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            lane_pc[0]   <= req_addr;
            lane_pc[1]   <= req_addr + 32'd4;
            lane_word[0] <= mem_data0;
            lane_word[1] <= mem_data1;
            lane_fault   <= {NUM_LANES{mem_fault}};    // fault covers the pair
        end
    end

    addr_stable_a: assert property (@(posedge clk) disable iff (fifo_rst)
        mem_req |=> !mem_req || $stable(mem_addr))
        else $error("mem_addr changed while mem_req was high");

endmodule

// File: hw/predecode_lane.sv
`timescale 1ns/1ns

module predecode_lane import ifu_pkg::*; (
    input  logic        clk,
    input  logic        fifo_rst,
    input  logic        redirect,
    input  logic        in_valid,
    input  logic [31:0] in_pc,
    input  logic [31:0] in_word,
    input  logic        in_fault,
    output logic        out_valid,
    output logic [31:0] out_pc,
    output logic [31:0] out_inst,
    output logic        out_fault,
    output inst_class_e out_class
);

    inst_class_e dec_class;

    always_comb begin
        if (in_fault) begin
            dec_class = IC_OTHER;    // word is garbage on a fault
        end else begin
            case (in_word[31:26])
                6'h00:          dec_class = IC_ALU;    // special, r-type
                OP_BEQ, OP_BNE: dec_class = IC_BRANCH;
                OP_J, OP_JAL:   dec_class = IC_JUMP;
                OP_LW:          dec_class = IC_LOAD;
                OP_SW:          dec_class = IC_STORE;
                default:        dec_class = IC_OTHER;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rst || redirect) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_pc    <= in_pc;
        out_inst  <= in_word;
        out_fault <= in_fault;
        out_class <= dec_class;
    end

endmodule

// File: hw/inst_fifo.sv
`timescale 1ns/1ns

module inst_fifo import ifu_pkg::*; (
    input  logic                 clk,
    input  logic                 fifo_rst,
    input  logic                 redirect,

    input  logic [NUM_LANES-1:0] wr_en,
    input  logic [31:0]          wr_pc [NUM_LANES],
    input  logic [31:0]          wr_inst [NUM_LANES],
    input  logic [NUM_LANES-1:0] wr_fault,
    input  inst_class_e          wr_class [NUM_LANES],

    input  logic                 issue0,    // master slot taken
    input  logic                 issue1,    // slave slot taken

    output logic                 slot0_valid,
    output logic [31:0]          slot0_pc,
    output logic [31:0]          slot0_inst,
    output logic                 slot0_fault,
    output inst_class_e          slot0_class,
    output logic                 slot1_valid,
    output logic [31:0]          slot1_pc,
    output logic [31:0]          slot1_inst,
    output logic                 slot1_fault,
    output inst_class_e          slot1_class,

    output logic                 in_delay_slot,
    output logic                 fifo_room
);

    // entry storage
    logic [31:0] mem_pc    [FIFO_DEPTH];
    logic [31:0] mem_inst  [FIFO_DEPTH];
    logic        mem_fault [FIFO_DEPTH];
    inst_class_e mem_class [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr_1;
    logic [PTR_W-1:0] rd_ptr_1;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free;
    logic [CNT_W-1:0] n_wr;
    logic [CNT_W-1:0] n_rd;
    logic             do_wr0;
    logic             do_wr1;
    logic             do_rd0;
    logic             do_rd1;

    assign wr_ptr_1 = wr_ptr + PTR_W'(1);    // wraps at 16
    assign rd_ptr_1 = rd_ptr + PTR_W'(1);

    // a redirect wins over anything arriving the same edge
    assign do_wr0 = wr_en[0] && !redirect;
    assign do_wr1 = wr_en[1] && wr_en[0] && !redirect;
    assign do_rd0 = issue0 && slot0_valid && !redirect;
    assign do_rd1 = issue1 && slot1_valid && do_rd0;

    assign n_wr = CNT_W'(do_wr0) + CNT_W'(do_wr1);
    assign n_rd = CNT_W'(do_rd0) + CNT_W'(do_rd1);

    assign free      = CNT_W'(FIFO_DEPTH) - count;
    assign fifo_room = (free >= CNT_W'(ROOM_MIN));

    // slot view of the two oldest entries
    assign slot0_valid = (count != '0);
    assign slot1_valid = (count > CNT_W'(1));

    assign slot0_pc    = mem_pc[rd_ptr];
    assign slot0_inst  = mem_inst[rd_ptr];
    assign slot0_fault = mem_fault[rd_ptr];
    assign slot0_class = mem_class[rd_ptr];
    assign slot1_pc    = mem_pc[rd_ptr_1];
    assign slot1_inst  = mem_inst[rd_ptr_1];
    assign slot1_fault = mem_fault[rd_ptr_1];
    assign slot1_class = mem_class[rd_ptr_1];

    always_ff @(posedge clk) begin
        if (do_wr0) begin
            mem_pc[wr_ptr]    <= wr_pc[0];
            mem_inst[wr_ptr]  <= wr_inst[0];
            mem_fault[wr_ptr] <= wr_fault[0];
            mem_class[wr_ptr] <= wr_class[0];
        end
        if (do_wr1) begin
            mem_pc[wr_ptr_1]    <= wr_pc[1];
            mem_inst[wr_ptr_1]  <= wr_inst[1];
            mem_fault[wr_ptr_1] <= wr_fault[1];
            mem_class[wr_ptr_1] <= wr_class[1];
        end
    end

    // pointers and count, all dropped back to empty on a redirect
    always_ff @(posedge clk) begin
        if (fifo_rst || redirect) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(n_wr);
            rd_ptr <= rd_ptr + PTR_W'(n_rd);
            count  <= count + n_wr - n_rd;
        end
    end

    // master went alone as a branch or jump, so the next master is its delay slot
    always_ff @(posedge clk) begin
        if (fifo_rst || redirect) begin
            in_delay_slot <= 1'b0;
        end else if (do_rd0) begin
            in_delay_slot <= (slot0_class == IC_BRANCH || slot0_class == IC_JUMP)
                             && !do_rd1;
        end
    end

    // pairs already past the room check must still fit
    no_overflow_a: assert property (@(posedge clk) disable iff (fifo_rst)
        (n_wr != '0) |-> (free >= n_wr))
        else $error("instruction fifo overflow, count %0d", count);

    issue_valid_a: assert property (@(posedge clk) disable iff (fifo_rst || redirect)
        (issue0 |-> slot0_valid) and (issue1 |-> (issue0 && slot1_valid)))
        else $error("issue of an empty slot");

endmodule

// File: hw/ifu_top.sv
`timescale 1ns/1ns

module ifu_top import ifu_pkg::*; (
    input  logic        clk,
    input  logic        fifo_rst,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic        mem_req,
    output logic [31:0] mem_addr,
    input  logic        mem_ack,
    input  logic [31:0] mem_data0,
    input  logic [31:0] mem_data1,
    input  logic        mem_fault,
    input  logic        issue0,
    input  logic        issue1,
    output logic        slot0_valid,
    output logic        slot1_valid,
    output logic [31:0] slot0_pc,
    output logic [31:0] slot1_pc,
    output logic [31:0] slot0_inst,
    output logic [31:0] slot1_inst,
    output logic        slot0_fault,
    output logic        slot1_fault,
    output inst_class_e slot0_class,
    output inst_class_e slot1_class,
    output logic        in_delay_slot
);

    // fetch controller to lanes
    logic [NUM_LANES-1:0] lane_valid;
    logic [31:0]          lane_pc [NUM_LANES];
    logic [31:0]          lane_word [NUM_LANES];
    logic [NUM_LANES-1:0] lane_fault;

    // lanes to fifo, before compaction
    logic [NUM_LANES-1:0] pd_valid;
    logic [31:0]          pd_pc [NUM_LANES];
    logic [31:0]          pd_inst [NUM_LANES];
    logic [NUM_LANES-1:0] pd_fault;
    inst_class_e          pd_class [NUM_LANES];

    // fifo write ports
    logic [NUM_LANES-1:0] wr_en;
    logic [31:0]          wr_pc [NUM_LANES];
    logic [31:0]          wr_inst [NUM_LANES];
    logic [NUM_LANES-1:0] wr_fault;
    inst_class_e          wr_class [NUM_LANES];
    logic                 lane1_only;
    logic                 fifo_room;

    fetch_ctrl u_fetch (
        .clk         (clk),
        .fifo_rst    (fifo_rst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fifo_room   (fifo_room),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_ack     (mem_ack),
        .mem_data0   (mem_data0),
        .mem_data1   (mem_data1),
        .mem_fault   (mem_fault),
        .lane_valid  (lane_valid),
        .lane_pc     (lane_pc),
        .lane_word   (lane_word),
        .lane_fault  (lane_fault)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        predecode_lane u_lane (
            .clk       (clk),
            .fifo_rst  (fifo_rst),
            .redirect  (redirect),
            .in_valid  (lane_valid[i]),
            .in_pc     (lane_pc[i]),
            .in_word   (lane_word[i]),
            .in_fault  (lane_fault[i]),
            .out_valid (pd_valid[i]),
            .out_pc    (pd_pc[i]),
            .out_inst  (pd_inst[i]),
            .out_fault (pd_fault[i]),
            .out_class (pd_class[i])
        );
    end

    // odd-word pair: lane 1 moves down to write port 0
    assign lane1_only  = pd_valid[1] && !pd_valid[0];
    assign wr_en       = {pd_valid[0] && pd_valid[1], pd_valid[0] || pd_valid[1]};
    assign wr_pc[0]    = lane1_only ? pd_pc[1]    : pd_pc[0];
    assign wr_inst[0]  = lane1_only ? pd_inst[1]  : pd_inst[0];
    assign wr_fault[0] = lane1_only ? pd_fault[1] : pd_fault[0];
    assign wr_class[0] = lane1_only ? pd_class[1] : pd_class[0];
    assign wr_pc[1]    = pd_pc[1];
    assign wr_inst[1]  = pd_inst[1];
    assign wr_fault[1] = pd_fault[1];
    assign wr_class[1] = pd_class[1];

    inst_fifo u_fifo (
        .clk           (clk),
        .fifo_rst      (fifo_rst),
        .redirect      (redirect),
        .wr_en         (wr_en),
        .wr_pc         (wr_pc),
        .wr_inst       (wr_inst),
        .wr_fault      (wr_fault),
        .wr_class      (wr_class),
        .issue0        (issue0),
        .issue1        (issue1),
        .slot0_valid   (slot0_valid),
        .slot0_pc      (slot0_pc),
        .slot0_inst    (slot0_inst),
        .slot0_fault   (slot0_fault),
        .slot0_class   (slot0_class),
        .slot1_valid   (slot1_valid),
        .slot1_pc      (slot1_pc),
        .slot1_inst    (slot1_inst),
        .slot1_fault   (slot1_fault),
        .slot1_class   (slot1_class),
        .in_delay_slot (in_delay_slot),
        .fifo_room     (fifo_room)
    );

endmodule

// File: sim/imem_model.sv
`timescale 1ns/1ns

module imem_model import ifu_pkg::*; (
    input  logic        clk,
    input  logic        mem_req,
    input  logic [31:0] mem_addr,
    output logic        mem_ack,
    output logic [31:0] mem_data0,
    output logic [31:0] mem_data1,
    output logic        mem_fault
);

    integer seed;
    integer delay;    // cycles left before ack, 0 when idle

    // opcode picked by a[6:4], low bits carry the word address
    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [5:0] op;
        case (a[6:4])
            3'd0:    op = 6'h00;
            3'd1:    op = OP_BEQ;
            3'd2:    op = OP_J;
            3'd3:    op = OP_LW;
            3'd4:    op = OP_SW;
            3'd5:    op = OP_BNE;
            3'd6:    op = OP_JAL;
            default: op = 6'h3f;
        endcase
        return {op, a[27:2]};
    endfunction

    initial begin
        seed      = 32'hb226f490;
        delay     = 0;
        mem_ack   = 1'b0;
        mem_data0 = '0;
        mem_data1 = '0;
        mem_fault = 1'b0;
    end

    // four-phase responder, driven on the falling edge
    always @(negedge clk) begin
        if (mem_req && !mem_ack) begin
            if (delay == 0) begin
                delay = 1 + ({$random(seed)} % 3);    // 1 to 3 cycles
            end
            delay = delay - 1;
            if (delay == 0) begin
                mem_ack   = 1'b1;
                mem_data0 = word_at(mem_addr);
                mem_data1 = word_at(mem_addr + 32'd4);
                mem_fault = (mem_addr >= 32'h400) && (mem_addr <= 32'h43f);
            end
        end else if (!mem_req && mem_ack) begin
            mem_ack = 1'b0;
        end
    end

endmodule

// File: sim/tb_ifu.sv
`timescale 1ns/1ns

module tb_ifu import ifu_pkg::*; ();

    logic        clk;
    logic        fifo_rst;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_ack;
    logic [31:0] mem_data0;
    logic [31:0] mem_data1;
    logic        mem_fault;
    logic        issue0;
    logic        issue1;
    logic        slot0_valid;
    logic        slot1_valid;
    logic [31:0] slot0_pc;
    logic [31:0] slot1_pc;
    logic [31:0] slot0_inst;
    logic [31:0] slot1_inst;
    logic        slot0_fault;
    logic        slot1_fault;
    inst_class_e slot0_class;
    inst_class_e slot1_class;
    logic        in_delay_slot;

    // one stimulus row: issue mode or redirect, plus a repeat count
    typedef struct packed {
        logic        i0;
        logic        i1;
        logic        redir;
        logic [31:0] rpc;
        logic [15:0] n;
    } row_t;

    localparam int NUM_ROWS = 12;
    row_t        rows [NUM_ROWS];
    int          errors;
    logic        timed_out;
    logic [31:0] ref_pc;    // next pc expected at slot 0
    logic        exp_ds;

    ifu_top dut_i (
        .clk(clk), .fifo_rst(fifo_rst), .redirect(redirect), .redirect_pc(redirect_pc),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack),
        .mem_data0(mem_data0), .mem_data1(mem_data1), .mem_fault(mem_fault),
        .issue0(issue0), .issue1(issue1),
        .slot0_valid(slot0_valid), .slot1_valid(slot1_valid),
        .slot0_pc(slot0_pc), .slot1_pc(slot1_pc),
        .slot0_inst(slot0_inst), .slot1_inst(slot1_inst),
        .slot0_fault(slot0_fault), .slot1_fault(slot1_fault),
        .slot0_class(slot0_class), .slot1_class(slot1_class),
        .in_delay_slot(in_delay_slot)
    );

    imem_model mem_i (
        .clk(clk), .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack),
        .mem_data0(mem_data0), .mem_data1(mem_data1), .mem_fault(mem_fault)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] word_at(input logic [31:0] a);
        logic [5:0] op;
        case (a[6:4])
            3'd0:    op = 6'h00;
            3'd1:    op = OP_BEQ;
            3'd2:    op = OP_J;
            3'd3:    op = OP_LW;
            3'd4:    op = OP_SW;
            3'd5:    op = OP_BNE;
            3'd6:    op = OP_JAL;
            default: op = 6'h3f;
        endcase
        return {op, a[27:2]};
    endfunction

    function automatic logic in_fault_range(input logic [31:0] a);
        return (a >= 32'h400) && (a <= 32'h43f);
    endfunction

    function automatic inst_class_e class_of(input logic [31:0] a);
        if (in_fault_range(a)) return IC_OTHER;
        case (a[6:4])
            3'd0:       return IC_ALU;
            3'd1, 3'd5: return IC_BRANCH;
            3'd2, 3'd6: return IC_JUMP;
            3'd3:       return IC_LOAD;
            3'd4:       return IC_STORE;
            default:    return IC_OTHER;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_entry(input int s, input logic [31:0] pc_exp, input logic [31:0] pc,
                               input logic [31:0] inst, input logic fault,
                               input inst_class_e cls);
        check_val($sformatf("slot%0d_pc", s), pc_exp, pc);
        check_val($sformatf("slot%0d_inst", s), word_at(pc_exp), inst);
        check_val($sformatf("slot%0d_fault", s), 32'(in_fault_range(pc_exp)), 32'(fault));
        check_val($sformatf("slot%0d_class", s), 32'(class_of(pc_exp)), 32'(cls));
    endtask

    // requests always ask for an aligned pair
    always @(negedge clk) begin
        if (!fifo_rst && mem_req) begin
            check_val("mem_addr[2:0]", 32'd0, 32'(mem_addr[2:0]));
        end
    end

    // queue must stay in pc order while nothing issues
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            if (slot0_valid) check_val("slot0_pc", ref_pc, slot0_pc);
            if (slot1_valid) check_val("slot1_pc", ref_pc + 32'd4, slot1_pc);
            check_val("in_delay_slot", 32'(exp_ds), 32'(in_delay_slot));
        end
    endtask

    task automatic issue_step(input logic dual);
        int waited;
        waited = 0;
        while (!(slot0_valid && (slot1_valid || !dual)) && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= 200) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout at %0t ns: issue slots never became valid", $time);
        end else begin
            check_entry(0, ref_pc, slot0_pc, slot0_inst, slot0_fault, slot0_class);
            if (slot1_valid) check_entry(1, ref_pc + 32'd4, slot1_pc, slot1_inst, slot1_fault,
                                         slot1_class);
            issue0 = 1'b1;
            issue1 = dual;
            exp_ds = (class_of(ref_pc) == IC_BRANCH || class_of(ref_pc) == IC_JUMP) && !dual;
            ref_pc = ref_pc + (dual ? 32'd8 : 32'd4);
            @(negedge clk);
            issue0 = 1'b0;
            issue1 = 1'b0;
            check_val("in_delay_slot", 32'(exp_ds), 32'(in_delay_slot));
        end
    endtask

    task automatic apply_redirect(input logic [31:0] pc);
        redirect    = 1'b1;
        redirect_pc = pc;
        @(negedge clk);
        redirect = 1'b0;
        ref_pc   = pc;
        exp_ds   = 1'b0;
        check_val("slot0_valid", 32'd0, 32'(slot0_valid));    // old words gone
        check_val("in_delay_slot", 32'd0, 32'(in_delay_slot));
    endtask

    initial begin
        clk         = 1'b0;
        fifo_rst    = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        issue0      = 1'b0;
        issue1      = 1'b0;
        errors      = 0;
        timed_out   = 1'b0;
        ref_pc      = RESET_PC;
        exp_ds      = 1'b0;
        // i0, i1, redirect, redirect_pc, count
        rows[0]  = {1'b1, 1'b0, 1'b0, 32'h0, 16'd12};
        rows[1]  = {1'b1, 1'b1, 1'b0, 32'h0, 16'd20};
        rows[2]  = {1'b0, 1'b0, 1'b0, 32'h0, 16'd60};    // let the queue fill
        rows[3]  = {1'b1, 1'b1, 1'b0, 32'h0, 16'd16};
        rows[4]  = {1'b0, 1'b0, 1'b1, 32'h0000_03f4, 16'd1};    // odd word, near faults
        rows[5]  = {1'b1, 1'b1, 1'b0, 32'h0, 16'd24};
        rows[6]  = {1'b1, 1'b0, 1'b0, 32'h0, 16'd10};
        rows[7]  = {1'b0, 1'b0, 1'b1, 32'h0000_0200, 16'd1};
        rows[8]  = {1'b0, 1'b0, 1'b0, 32'h0, 16'd40};
        rows[9]  = {1'b1, 1'b0, 1'b0, 32'h0, 16'd8};
        rows[10] = {1'b0, 1'b0, 1'b1, 32'h0000_0a0c, 16'd1};
        rows[11] = {1'b1, 1'b1, 1'b0, 32'h0, 16'd12};
        repeat (3) @(negedge clk);
        check_val("mem_req", 32'd0, 32'(mem_req));
        check_val("slot0_valid", 32'd0, 32'(slot0_valid));
        check_val("slot1_valid", 32'd0, 32'(slot1_valid));
        check_val("in_delay_slot", 32'd0, 32'(in_delay_slot));
        fifo_rst = 1'b0;
        for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
            if (rows[r].redir) begin
                apply_redirect(rows[r].rpc);
            end else if (rows[r].i0) begin
                for (int k = 0; k < int'(rows[r].n) && !timed_out; k++) begin
                    issue_step(rows[r].i1);
                end
            end else begin
                idle_cycles(int'(rows[r].n));
            end
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sources.f
hw/ifu_pkg.sv
hw/fetch_ctrl.sv
hw/predecode_lane.sv
hw/inst_fifo.sv
hw/ifu_top.sv
sim/imem_model.sv
sim/tb_ifu.sv
